/* compile.f */
src/redundancy_pkg.sv
src/sync_timer.sv
src/req_voter.sv
src/req_comparator.sv
src/hart_isolator.sv
src/fetch_router.sv
src/mode_fsm.sv
src/redundancy_wrapper.sv
testbench/tb_redundancy_wrapper.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
# A failed build or a failing simulation gives a non-zero exit status.
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing -Wno-fatal -j 0 \
  --top-module tb_redundancy_wrapper \
  -f compile.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Vtb_redundancy_wrapper
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi
exit 0

/* src/fetch_router.sv */
// Steers fetch requests to memory ports and responses back to the harts.
// No buffering; gnt and rvalid of the driven port pass back combinationally.
// An unknown mode encoding routes as single mode.
`timescale 1ns/1ps
`default_nettype none

module fetch_router (
  input  redundancy_pkg::red_mode_t                                mode_i,
  input  redundancy_pkg::hart_mask_t                               master_i,
  input  redundancy_pkg::hart_mask_t                               pair_i,
  input  redundancy_pkg::bus_req_t [redundancy_pkg::NUM_HARTS-1:0] hart_req_i,
  input  redundancy_pkg::bus_req_t                                 voted_req_i,
  input  redundancy_pkg::bus_req_t                                 cmp_req_i,
  input  redundancy_pkg::bus_rsp_t [redundancy_pkg::NUM_HARTS-1:0] iso_rsp_i,
  input  redundancy_pkg::bus_rsp_t [redundancy_pkg::NUM_HARTS-1:0] mem_rsp_i,
  output redundancy_pkg::bus_req_t [redundancy_pkg::NUM_HARTS-1:0] mem_req_o,
  output redundancy_pkg::bus_rsp_t [redundancy_pkg::NUM_HARTS-1:0] hart_rsp_o,
  output redundancy_pkg::hart_mask_t                               isolate_o
);
  import redundancy_pkg::*;

  bus_rsp_t master_rsp;

  // Response of the master's memory port
  always_comb begin
    master_rsp = '0;
    for (int i = 0; i < NUM_HARTS; i++) begin
      if (master_i[i]) begin
        master_rsp = mem_rsp_i[i];
      end
    end
  end

  always_comb begin
    mem_req_o  = '0;
    hart_rsp_o = '0;
    isolate_o  = '0;
    case (mode_i)
      MODE_TMR: begin
        // Voted request on the master port, everyone shares its answer
        for (int i = 0; i < NUM_HARTS; i++) begin
          if (master_i[i]) begin
            mem_req_o[i] = voted_req_i;
          end
          hart_rsp_o[i] = master_rsp;
        end
      end
      MODE_DMR: begin
        isolate_o = ~pair_i;
        for (int i = 0; i < NUM_HARTS; i++) begin
          if (master_i[i]) begin
            mem_req_o[i] = cmp_req_i;
          end
          // Third hart is fed by the isolator
          if (pair_i[i]) begin
            hart_rsp_o[i] = master_rsp;
          end else begin
            hart_rsp_o[i] = iso_rsp_i[i];
          end
        end
      end
      default: begin
        mem_req_o  = hart_req_i;
        hart_rsp_o = mem_rsp_i;
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/hart_isolator.sv */
// Answers fetches of isolated harts with WFI so they park themselves.
// Grants at once, rvalid follows one cycle after each grant.
`timescale 1ns/1ps
`default_nettype none

module hart_isolator (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,
  input  redundancy_pkg::bus_req_t [redundancy_pkg::NUM_HARTS-1:0] req_i,
  input  redundancy_pkg::hart_mask_t                               isolate_i,
  output redundancy_pkg::bus_rsp_t [redundancy_pkg::NUM_HARTS-1:0] rsp_o
);
  import redundancy_pkg::*;

  hart_mask_t gnt;
  hart_mask_t valid_q;

  // Grants are all zero while no hart is isolated
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= gnt;
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_HARTS; i++) begin
      gnt[i]          = isolate_i[i] & req_i[i].req;
      rsp_o[i].gnt    = gnt[i];
      rsp_o[i].rvalid = valid_q[i];
      rsp_o[i].rdata  = WFI_OPCODE;
    end
  end

endmodule

`default_nettype wire

/* src/mode_fsm.sv */
// Mode control for the redundancy wrapper. A new configuration only takes
// effect once all harts sleep; errors are acted on in ST_RUN only, so a fault
// raised while waiting for sleep is not seen.
`timescale 1ns/1ps
`default_nettype none

module mode_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  redundancy_pkg::mode_cfg_t  mode_cfg_i,
  input  redundancy_pkg::hart_mask_t sleep_i,
  input  logic                       vote_err_i,
  input  redundancy_pkg::hart_mask_t vote_err_hart_i,
  input  logic                       cmp_err_i,
  input  logic                       timer_expired_i,
  output logic                       timer_start_o,
  output logic                       timer_run_o,
  output redundancy_pkg::red_mode_t  mode_o,
  output redundancy_pkg::hart_mask_t master_o,
  output redundancy_pkg::hart_mask_t pair_o,
  output redundancy_pkg::hart_mask_t fault_hart_o,
  output logic                       irq_o
);
  import redundancy_pkg::*;

  typedef enum logic [1:0] {
    ST_RUN,
    ST_WAIT_SLEEP,
    ST_FAULT
  } state_e;

  state_e     state_q, state_d;
  red_mode_t  mode_q, mode_d;
  hart_mask_t master_q, master_d;
  hart_mask_t pair_q, pair_d;
  hart_mask_t fault_q, fault_d;
  mode_cfg_t  pend_q;
  logic       master_ok, pair_ok, cfg_ok, red_err;

  // Configuration checks
  always_comb begin
    master_ok = (mode_cfg_i.master != '0) &&
                ((mode_cfg_i.master & (mode_cfg_i.master - hart_mask_t'(1))) == '0);
    pair_ok   = ($countones(mode_cfg_i.pair) == 2) && |(mode_cfg_i.pair & mode_cfg_i.master);
    cfg_ok    = mode_cfg_i.valid && master_ok &&
                ((mode_cfg_i.mode == MODE_SINGLE) || (mode_cfg_i.mode == MODE_TMR) ||
                 ((mode_cfg_i.mode == MODE_DMR) && pair_ok));
  end

  // Voter errors count in TMR only, comparator errors in DMR only
  assign red_err = ((mode_q == MODE_TMR) && vote_err_i) || ((mode_q == MODE_DMR) && cmp_err_i);

  always_comb begin
    state_d       = state_q;
    mode_d        = mode_q;
    master_d      = master_q;
    pair_d        = pair_q;
    fault_d       = fault_q;
    timer_start_o = 1'b0;
    case (state_q)
      ST_RUN: begin
        if (red_err) begin
          state_d = ST_FAULT;
          mode_d  = MODE_SINGLE;
          fault_d = (mode_q == MODE_TMR) ? vote_err_hart_i : pair_q;
        end else if (cfg_ok) begin
          state_d       = ST_WAIT_SLEEP;
          timer_start_o = 1'b1;
          fault_d       = '0;
        end
      end
      ST_WAIT_SLEEP: begin
        if (&sleep_i) begin
          state_d  = ST_RUN;
          mode_d   = pend_q.mode;
          master_d = pend_q.master;
          pair_d   = pend_q.pair;
        end else if (timer_expired_i) begin
          // Harts never all slept, give up on the change
          state_d = ST_FAULT;
          mode_d  = MODE_SINGLE;
        end
      end
      default: begin
        state_d = ST_RUN;
      end
    endcase
  end

  assign timer_run_o = timer_start_o || (state_q == ST_WAIT_SLEEP);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ST_RUN;
      mode_q   <= MODE_SINGLE;
      master_q <= hart_mask_t'(1);
      pair_q   <= '0;
      fault_q  <= '0;
    end else begin
      state_q  <= state_d;
      mode_q   <= mode_d;
      master_q <= master_d;
      pair_q   <= pair_d;
      fault_q  <= fault_d;
    end
  end

  // Pending configuration, applied once every hart sleeps
  always_ff @(posedge clk_i) begin
    if (timer_start_o) begin
      pend_q <= mode_cfg_i;
    end
  end

  assign mode_o       = mode_q;
  assign master_o     = master_q;
  assign pair_o       = pair_q;
  assign fault_hart_o = fault_q;
  assign irq_o        = (state_q == ST_FAULT);

endmodule

`default_nettype wire

/* src/redundancy_pkg.sv */
// Shared types and constants for the three-hart fetch redundancy wrapper.
// The hart count is fixed at three; the voter and the dual-mode pair logic
// rely on it. Only the instruction fetch bus is covered.
`default_nettype none

package redundancy_pkg;

  localparam int unsigned NUM_HARTS = 3;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // One bit per hart, bit i is hart i
  typedef logic [NUM_HARTS-1:0] hart_mask_t;

  // Wide enough to hold SYNC_TIMEOUT_CYCLES
  typedef logic [4:0] timer_cnt_t;

  // Fetch request, held by the hart until gnt
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    MODE_SINGLE = 2'd0,
    MODE_TMR    = 2'd1,
    MODE_DMR    = 2'd2
  } red_mode_t;

  // Master is one-hot, pair holds two bits including the master (DMR only)
  typedef struct packed {
    logic       valid;
    red_mode_t  mode;
    hart_mask_t master;
    hart_mask_t pair;
  } mode_cfg_t;

  localparam data_t WFI_OPCODE = 32'h1050_0073;

  localparam timer_cnt_t SYNC_TIMEOUT_CYCLES = 5'd16;

endpackage

`default_nettype wire

/* src/redundancy_wrapper.sv */
// Three-hart fetch redundancy wrapper: single, TMR and same-cycle DMR.
// Mode changes wait for all harts to sleep. Cores and memories are outside.
`timescale 1ns/1ps
`default_nettype none

module redundancy_wrapper (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,
  input  redundancy_pkg::bus_req_t [redundancy_pkg::NUM_HARTS-1:0] hart_req_i,
  output redundancy_pkg::bus_rsp_t [redundancy_pkg::NUM_HARTS-1:0] hart_rsp_o,
  output redundancy_pkg::bus_req_t [redundancy_pkg::NUM_HARTS-1:0] mem_req_o,
  input  redundancy_pkg::bus_rsp_t [redundancy_pkg::NUM_HARTS-1:0] mem_rsp_i,
  input  redundancy_pkg::mode_cfg_t                                mode_cfg_i,
  input  redundancy_pkg::hart_mask_t                               sleep_i,
  output redundancy_pkg::red_mode_t                                mode_o,
  output redundancy_pkg::hart_mask_t                               master_o,
  output redundancy_pkg::hart_mask_t                               fault_hart_o,
  output logic                                                     irq_o
);
  import redundancy_pkg::*;

  red_mode_t                 cur_mode;
  hart_mask_t                cur_master, cur_pair, isolate;
  logic                      timer_start, timer_run, timer_expired;
  bus_req_t                  voted_req, cmp_req;
  logic                      vote_err, cmp_err;
  hart_mask_t                vote_err_hart;
  bus_rsp_t [NUM_HARTS-1:0]  iso_rsp;

  mode_fsm u_mode_fsm (
    .clk_i, .rst_ni, .mode_cfg_i, .sleep_i,
    .vote_err_i      (vote_err),
    .vote_err_hart_i (vote_err_hart),
    .cmp_err_i       (cmp_err),
    .timer_expired_i (timer_expired),
    .timer_start_o   (timer_start),
    .timer_run_o     (timer_run),
    .mode_o          (cur_mode),
    .master_o        (cur_master),
    .pair_o          (cur_pair),
    .fault_hart_o,
    .irq_o
  );

  sync_timer u_sync_timer (
    .clk_i, .rst_ni,
    .start_i   (timer_start),
    .run_i     (timer_run),
    .expired_o (timer_expired)
  );

  req_voter u_req_voter (
    .req_i      (hart_req_i),
    .voted_o    (voted_req),
    .err_o      (vote_err),
    .err_hart_o (vote_err_hart)
  );

  req_comparator u_req_comparator (
    .req_i    (hart_req_i),
    .master_i (cur_master),
    .pair_i   (cur_pair),
    .req_o    (cmp_req),
    .err_o    (cmp_err)
  );

  hart_isolator u_hart_isolator (
    .clk_i, .rst_ni,
    .req_i     (hart_req_i),
    .isolate_i (isolate),
    .rsp_o     (iso_rsp)
  );

  fetch_router u_fetch_router (
    .mode_i      (cur_mode),
    .master_i    (cur_master),
    .pair_i      (cur_pair),
    .hart_req_i,
    .voted_req_i (voted_req),
    .cmp_req_i   (cmp_req),
    .iso_rsp_i   (iso_rsp),
    .mem_rsp_i,
    .mem_req_o,
    .hart_rsp_o,
    .isolate_o   (isolate)
  );

  assign mode_o   = cur_mode;
  assign master_o = cur_master;

endmodule

`default_nettype wire

/* src/req_comparator.sv */
// Same-cycle lockstep compare of the master and its dual-mode partner.
// Expects a one-hot master and a pair with two bits that include it.
`timescale 1ns/1ps
`default_nettype none

module req_comparator (
  input  redundancy_pkg::bus_req_t [redundancy_pkg::NUM_HARTS-1:0] req_i,
  input  redundancy_pkg::hart_mask_t                               master_i,
  input  redundancy_pkg::hart_mask_t                               pair_i,
  output redundancy_pkg::bus_req_t                                 req_o,
  output logic                                                     err_o
);
  import redundancy_pkg::*;

  hart_mask_t partner;
  bus_req_t   partner_req;

  assign partner = pair_i & ~master_i;

  // One-hot selects
  always_comb begin
    req_o       = '0;
    partner_req = '0;
    for (int i = 0; i < NUM_HARTS; i++) begin
      if (master_i[i]) begin
        req_o = req_i[i];
      end
      if (partner[i]) begin
        partner_req = req_i[i];
      end
    end
  end

  assign err_o = (req_o != partner_req);

endmodule

`default_nettype wire

/* src/req_voter.sv */
// Bitwise two-of-three vote over the full fetch request, including the
// write fields. Purely combinational.
`timescale 1ns/1ps
`default_nettype none

module req_voter (
  input  redundancy_pkg::bus_req_t [redundancy_pkg::NUM_HARTS-1:0] req_i,
  output redundancy_pkg::bus_req_t                                 voted_o,
  output logic                                                     err_o,
  output redundancy_pkg::hart_mask_t                               err_hart_o
);
  import redundancy_pkg::*;

  bus_req_t a, b, c;

  assign a = req_i[0];
  assign b = req_i[1];
  assign c = req_i[2];

  // Majority per bit
  always_comb begin
    voted_o = (a & b) | (a & c) | (b & c);
  end

  // Any disagreement at all, even one the vote masks
  assign err_o = (a != b) || (b != c);

  // Harts that lost the vote on at least one bit
  always_comb begin
    err_hart_o = '0;
    for (int i = 0; i < NUM_HARTS; i++) begin
      if (req_i[i] != voted_o) begin
        err_hart_o[i] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/sync_timer.sv */
// Wait timer for the sleep handshake. A run that starts in the same cycle
// as the clear counts that cycle as the first.
`timescale 1ns/1ps
`default_nettype none

module sync_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic run_i,
  output logic expired_o
);
  import redundancy_pkg::*;

  timer_cnt_t cnt_q, cnt_d;

  always_comb begin
    cnt_d = start_i ? '0 : cnt_q;
    // Saturates at the limit
    if (run_i && (cnt_d != SYNC_TIMEOUT_CYCLES)) begin
      cnt_d = cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign expired_o = (cnt_q == SYNC_TIMEOUT_CYCLES);

endmodule

`default_nettype wire

/* testbench/redundancy_testdata.hex */
// rep cfg_valid cfg_mode cfg_master cfg_pair sleep req addr_op(0 keep 1 new 2 shared) flip gnt rvalid
// exp: mem_req0-2 (0 idle, 1-3 hart) hart_rsp0-2 (0 none, 1-3 port, 4/5 WFI) mode master irq fault
1 0 0 0 0 0 7 1 0 7 0  1 2 3 1 2 3 0 1 0 0  // single mode pass-through
2 0 0 0 0 0 7 0 0 2 5  1 2 3 1 2 3 0 1 0 0  // back-pressure on ports 0 and 2
1 0 0 0 0 0 5 1 0 7 2  1 2 3 1 2 3 0 1 0 0
1 1 1 2 0 0 7 2 0 7 0  1 2 3 1 2 3 0 1 0 0  // request TMR, master hart 1
3 0 0 0 0 3 0 0 0 7 0  1 2 3 1 2 3 0 1 0 0  // waiting, not all asleep
1 0 0 0 0 7 0 0 0 7 0  1 2 3 1 2 3 0 1 0 0  // all asleep
1 0 0 0 0 0 7 2 0 7 0  0 2 0 2 2 2 1 2 0 0  // TMR active
2 0 0 0 0 0 7 0 0 5 2  0 2 0 2 2 2 1 2 0 0
1 0 0 0 0 0 7 0 4 7 2  0 2 0 2 2 2 1 2 0 0  // hart 2 disagrees
1 0 0 0 0 0 7 0 0 7 0  1 2 3 1 2 3 0 2 1 4
1 0 0 0 0 0 7 0 0 7 0  1 2 3 1 2 3 0 2 0 4
1 1 2 4 5 7 0 0 0 7 0  1 2 3 1 2 3 0 2 0 4  // request DMR, master hart 2 with hart 0
1 0 0 0 0 7 0 0 0 7 0  1 2 3 1 2 3 0 2 0 0
1 0 0 0 0 0 7 2 0 7 0  0 0 3 3 4 3 2 4 0 0  // DMR active, hart 1 isolated
1 0 0 0 0 0 5 0 0 3 4  0 0 3 3 5 3 2 4 0 0
1 0 0 0 0 0 7 0 2 7 0  0 0 3 3 4 3 2 4 0 0  // isolated hart differs, no fault
1 0 0 0 0 0 7 0 1 7 0  0 0 3 3 5 3 2 4 0 0  // partner mismatch
1 0 0 0 0 0 7 0 0 7 0  1 2 3 1 2 3 0 4 1 5
1 0 0 0 0 0 7 0 0 7 0  1 2 3 1 2 3 0 4 0 5
1 1 1 3 0 7 0 1 0 7 0  1 2 3 1 2 3 0 4 0 5  // master not one-hot
2 0 0 0 0 7 0 0 0 7 0  1 2 3 1 2 3 0 4 0 5
1 1 1 1 0 0 7 1 0 7 0  1 2 3 1 2 3 0 4 0 5  // request TMR that never syncs
10 0 0 0 0 3 7 0 0 7 0  1 2 3 1 2 3 0 4 0 0
1 0 0 0 0 3 7 0 0 7 0  1 2 3 1 2 3 0 4 1 0  // timeout irq
1 0 0 0 0 0 7 0 0 7 0  1 2 3 1 2 3 0 4 0 0

/* testbench/tb_redundancy_wrapper.sv */
// Vector testbench for the fetch redundancy wrapper. Run from the project root
// so that the data file path resolves. Each data line repeats for its count of
// cycles and stops the run at the first mismatch.
`timescale 1ns/1ps
`default_nettype none

module tb_redundancy_wrapper;
  import redundancy_pkg::*;

  localparam int NUM_LINES  = 25;
  localparam int NUM_FIELDS = 21;
  localparam int RST_CYCLES = 10;
  // Standard RISC-V WFI encoding
  localparam logic [31:0] WFI_INSN  = 32'h1050_0073;
  localparam logic [31:0] FLIP_BITS = 32'h0000_0040;

  logic                     clk = 1'b0;
  logic                     rst_n;
  bus_req_t [NUM_HARTS-1:0] hart_req;
  bus_rsp_t [NUM_HARTS-1:0] hart_rsp;
  bus_req_t [NUM_HARTS-1:0] mem_req;
  bus_rsp_t [NUM_HARTS-1:0] mem_rsp;
  mode_cfg_t                mode_cfg;
  hart_mask_t               sleep_mask;
  red_mode_t                mode;
  hart_mask_t               master;
  hart_mask_t               fault_hart;
  logic                     irq;

  logic [7:0] vec_mem [0:NUM_LINES*NUM_FIELDS-1];
  addr_t      base_addr [NUM_HARTS];
  integer     seed;
  int         total_cycles;
  int         max_cycles = 100000;
  int         cycle_cnt = 0;
  int         vec_cycle;

  redundancy_wrapper u_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .hart_req_i   (hart_req),
    .hart_rsp_o   (hart_rsp),
    .mem_req_o    (mem_req),
    .mem_rsp_i    (mem_rsp),
    .mode_cfg_i   (mode_cfg),
    .sleep_i      (sleep_mask),
    .mode_o       (mode),
    .master_o     (master),
    .fault_hart_o (fault_hart),
    .irq_o        (irq)
  );

  always #4 clk = ~clk;

  task automatic stop_with_fail();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped");
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      stop_with_fail();
    end
  end

  task automatic check_req(input string name, input bus_req_t got, input bus_req_t exp);
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h (cycle %0d)", name, got, exp, vec_cycle);
      stop_with_fail();
    end
  endtask

  task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h (cycle %0d)", name, got, exp, vec_cycle);
      stop_with_fail();
    end
  endtask

  task automatic check_mode(input string name, input red_mode_t got, input red_mode_t exp);
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h (cycle %0d)", name, got, exp, vec_cycle);
      stop_with_fail();
    end
  endtask

  task automatic check_mask(input string name, input hart_mask_t got, input hart_mask_t exp);
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h (cycle %0d)", name, got, exp, vec_cycle);
      stop_with_fail();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s = %h, expected %h (cycle %0d)", name, got, exp, vec_cycle);
      stop_with_fail();
    end
  endtask

  // Code 0 is an idle port, 1 to 3 name the hart whose request it carries
  function automatic bus_req_t expected_mem_req(input logic [7:0] code);
    bus_req_t exp;
    exp = '0;
    if (code != 8'h0) begin
      exp = hart_req[int'(code) - 1];
    end
    return exp;
  endfunction

  // 1 to 3 pick a memory port, 4 and 5 are WFI answers without and with rvalid
  function automatic bus_rsp_t expected_hart_rsp(input logic [7:0] code, input int hart);
    bus_rsp_t exp;
    exp = '0;
    if ((code >= 8'h1) && (code <= 8'h3)) begin
      exp = mem_rsp[int'(code) - 1];
    end else if (code >= 8'h4) begin
      exp.gnt    = hart_req[hart].req;
      exp.rvalid = (code == 8'h5);
      exp.rdata  = WFI_INSN;
    end
    return exp;
  endfunction

  task automatic drive_cycle(input int base);
    hart_mask_t req_mask;
    hart_mask_t flip_mask;
    hart_mask_t gnt_mask;
    hart_mask_t valid_mask;
    addr_t      shared_addr;
    req_mask   = vec_mem[base+6][2:0];
    flip_mask  = vec_mem[base+8][2:0];
    gnt_mask   = vec_mem[base+9][2:0];
    valid_mask = vec_mem[base+10][2:0];
    // New addresses per hart, or one address shared by all harts
    if (vec_mem[base+7] == 8'h1) begin
      for (int i = 0; i < NUM_HARTS; i++) begin
        base_addr[i] = $random(seed);
      end
    end else if (vec_mem[base+7] == 8'h2) begin
      shared_addr = $random(seed);
      for (int i = 0; i < NUM_HARTS; i++) begin
        base_addr[i] = shared_addr;
      end
    end
    mode_cfg.valid  <= vec_mem[base+1][0];
    mode_cfg.mode   <= red_mode_t'(vec_mem[base+2][1:0]);
    mode_cfg.master <= vec_mem[base+3][2:0];
    mode_cfg.pair   <= vec_mem[base+4][2:0];
    sleep_mask      <= vec_mem[base+5][2:0];
    for (int i = 0; i < NUM_HARTS; i++) begin
      hart_req[i].req   <= req_mask[i];
      hart_req[i].we    <= 1'b0;
      hart_req[i].be    <= 4'hf;
      hart_req[i].addr  <= flip_mask[i] ? (base_addr[i] ^ FLIP_BITS) : base_addr[i];
      hart_req[i].wdata <= '0;
      mem_rsp[i].gnt    <= gnt_mask[i];
      mem_rsp[i].rvalid <= valid_mask[i];
      mem_rsp[i].rdata  <= data_t'(32'hDA7A_0000 + (vec_cycle << 4) + i);
    end
  endtask

  task automatic check_cycle(input int base);
    for (int i = 0; i < NUM_HARTS; i++) begin
      check_req($sformatf("mem_req_o[%0d]", i), mem_req[i],
                expected_mem_req(vec_mem[base+11+i]));
      check_rsp($sformatf("hart_rsp_o[%0d]", i), hart_rsp[i],
                expected_hart_rsp(vec_mem[base+14+i], i));
    end
    check_mode("mode_o", mode, red_mode_t'(vec_mem[base+17][1:0]));
    check_mask("master_o", master, vec_mem[base+18][2:0]);
    check_bit("irq_o", irq, vec_mem[base+19][0]);
    check_mask("fault_hart_o", fault_hart, vec_mem[base+20][2:0]);
  endtask

  initial begin
    seed       = 11221;
    rst_n      = 1'b0;
    mode_cfg   = '0;
    sleep_mask = '0;
    hart_req   = '0;
    mem_rsp    = '0;
    vec_cycle  = 0;
    foreach (base_addr[i]) begin
      base_addr[i] = '0;
    end
    $readmemh("testbench/redundancy_testdata.hex", vec_mem);
    total_cycles = 0;
    for (int l = 0; l < NUM_LINES; l++) begin
      if ($isunknown(vec_mem[l*NUM_FIELDS]) || (vec_mem[l*NUM_FIELDS] == 8'h0)) begin
        $display("Test data line %0d is missing or has a zero repeat count", l + 1);
        stop_with_fail();
      end else begin
        total_cycles += int'(vec_mem[l*NUM_FIELDS]);
      end
    end
    max_cycles = total_cycles + RST_CYCLES + 20;

    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    for (int l = 0; l < NUM_LINES; l++) begin
      for (int r = 0; r < int'(vec_mem[l*NUM_FIELDS]); r++) begin
        @(posedge clk);
        drive_cycle(l * NUM_FIELDS);
        // Outputs settle well before the falling edge
        @(negedge clk);
        check_cycle(l * NUM_FIELDS);
        vec_cycle++;
      end
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
